/* vlog.f */
+incdir+.
rv_isa_pkg.sv
rv_pipe_pkg.sv
pipe_if.sv
fetch_stage.sv
register_file.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
core_top.sv
tb_core.sv

/* Makefile */
TOP := tb_core

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f vlog.f --top-module $(TOP) --Mdir obj_dir -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf obj_dir

/* tb_core.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rv_macros.svh"

module tb_core;

  localparam int HALF_PERIOD = 4;
  localparam int PROG_LEN = 112;
  localparam int MEM_LEN = 128;
  localparam int MAX_WAIT = 3;
  // Worst case per instruction is one cycle plus a store with all wait states
  localparam int WATCHDOG_NS = (MEM_LEN * (1 + MAX_WAIT + 2) + 40) * 2 * HALF_PERIOD;
  localparam logic [31:0] DONE_ADDR = 32'(MEM_LEN * 4);

  typedef enum int {
    op_add, op_sub, op_and, op_or, op_xor, op_slt, op_sll, op_srl,
    op_addi, op_andi, op_ori, op_xori, op_slti, op_lui, op_sw
  } instr_kind_t;

  logic clock = 1'b0;
  logic reset = 1'b1;
  rv_isa_pkg::word_t inst_addr;
  rv_isa_pkg::inst_t inst;
  rv_isa_pkg::word_t paddr;
  logic psel;
  logic penable;
  logic pwrite;
  rv_isa_pkg::word_t pwdata;
  logic pready = 1'b0;

  logic [31:0] rng_state = 32'h65ecce05;
  logic [31:0] prog [0:MEM_LEN-1];
  logic [31:0] ref_regs [0:31];
  logic [4:0] recent_rd [0:2];
  int prog_count = 0;

  // Stores predicted by the reference model, in program order
  logic [31:0] exp_addr [0:MEM_LEN-1];
  logic [31:0] exp_data [0:MEM_LEN-1];
  logic exp_zero [0:MEM_LEN-1];
  int exp_count = 0;
  int store_idx = 0;
  logic exp_valid = 1'b0;
  logic [31:0] exp_paddr = '0;
  logic [31:0] exp_pwdata = '0;
  logic exp_zero_now = 1'b0;

  logic xfer;
  logic xfer_done = 1'b0;
  logic prev_reset = 1'b1;
  rv_isa_pkg::word_t prev_inst_addr = '0;
  int wait_count = 0;
  int fetch_errors = 0;
  int apb_errors = 0;
  int store_errors = 0;

  always #HALF_PERIOD clock = ~clock;

  core_top u_core_top (
    .clock     (clock),
    .reset     (reset),
    .inst_addr (inst_addr),
    .inst      (inst),
    .paddr     (paddr),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .pwdata    (pwdata),
    .pready    (pready)
  );

  // Combinational instruction memory, NOP outside the program
  assign inst = (inst_addr[31:9] == '0) ? prog[inst_addr[8:2]] : `RV_NOP;

  function automatic logic [31:0] draw_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // Mostly a recent destination, which gives hazards at distance 1 to 3
  function automatic logic [4:0] pick_source();
    logic [31:0] r;
    r = draw_random();
    if (r[1:0] != 2'b00) return recent_rd[int'(r[3:2]) % 3];
    return {2'b00, r[6:4]};
  endfunction

  // Encodes one instruction and runs it on the architectural model
  task automatic append_instr(input instr_kind_t kind, input logic [4:0] rd,
                              input logic [4:0] rs1, input logic [4:0] rs2,
                              input logic [19:0] imm);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] b_op;
    logic [31:0] imm_i;
    logic [31:0] res;
    logic [31:0] word;
    logic [6:0] f7;
    logic [2:0] f3;
    a = ref_regs[rs1];
    b = ref_regs[rs2];
    imm_i = {{20{imm[11]}}, imm[11:0]};
    b_op = (kind >= op_addi) ? imm_i : b;
    f7 = (kind == op_sub) ? 7'b0100000 : 7'b0000000;
    case (kind)
      op_sll: f3 = 3'b001;
      op_slt, op_slti, op_sw: f3 = 3'b010;
      op_xor, op_xori: f3 = 3'b100;
      op_srl: f3 = 3'b101;
      op_or, op_ori: f3 = 3'b110;
      op_and, op_andi: f3 = 3'b111;
      default: f3 = 3'b000;
    endcase
    case (kind)
      op_add, op_addi: res = a + b_op;
      op_sub: res = a - b_op;
      op_and, op_andi: res = a & b_op;
      op_or, op_ori: res = a | b_op;
      op_xor, op_xori: res = a ^ b_op;
      op_slt, op_slti: res = {31'b0, $signed(a) < $signed(b_op)};
      op_sll: res = a << b_op[4:0];
      op_srl: res = a >> b_op[4:0];
      op_lui: res = {imm, 12'b0};
      default: res = '0;
    endcase
    if (kind == op_lui) word = {imm, rd, 7'b0110111};
    else if (kind == op_sw) word = {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    else if (kind >= op_addi) word = {imm[11:0], rs1, f3, rd, 7'b0010011};
    else word = {f7, rs2, rs1, f3, rd, 7'b0110011};
    prog[prog_count] = word;
    prog_count++;
    if (kind == op_sw) begin
      exp_addr[exp_count] = a + imm_i;
      exp_data[exp_count] = b;
      exp_zero[exp_count] = (rs2 == 5'd0);
      exp_count++;
    end else begin
      // x0 stays zero whatever is written to it
      if (rd != 5'd0) ref_regs[rd] = res;
      recent_rd[2] = recent_rd[1];
      recent_rd[1] = recent_rd[0];
      recent_rd[0] = rd;
    end
  endtask

  task automatic build_program();
    logic [31:0] r;
    logic [31:0] imm;
    logic [4:0] rs1;
    logic [4:0] rs2;
    int sel;
    for (int i = 0; i < MEM_LEN; i++) prog[i] = `RV_NOP;
    for (int i = 0; i < 32; i++) ref_regs[i] = '0;
    recent_rd[0] = 5'd1;
    recent_rd[1] = 5'd2;
    recent_rd[2] = 5'd3;
    // Write to x0, store x0, then a dependent chain into a store
    append_instr(op_addi, 5'd0, 5'd0, 5'd0, 20'h005a5);
    append_instr(op_sw, 5'd0, 5'd0, 5'd0, 20'h00010);
    append_instr(op_lui, 5'd1, 5'd0, 5'd0, 20'hbeef1);
    append_instr(op_addi, 5'd1, 5'd1, 5'd0, 20'h00123);
    append_instr(op_sw, 5'd0, 5'd0, 5'd1, 20'h00020);
    while (prog_count < PROG_LEN) begin
      r = draw_random();
      imm = draw_random();
      rs1 = pick_source();
      rs2 = pick_source();
      sel = int'(r % 32'd20);
      append_instr((sel >= 14) ? op_sw : instr_kind_t'(sel), {2'b00, r[10:8]}, rs1, rs2,
                   imm[19:0]);
    end
  endtask

  assign xfer = psel && penable && pready;

  always @(posedge clock) begin
    prev_reset <= reset;
    prev_inst_addr <= inst_addr;
    xfer_done <= xfer;
  end

  always @(negedge clock) begin
    if (xfer_done) store_idx = store_idx + 1;
    exp_valid = (store_idx < exp_count);
    if (exp_valid) begin
      exp_paddr = exp_addr[store_idx];
      exp_pwdata = exp_data[store_idx];
      exp_zero_now = exp_zero[store_idx];
    end
  end

  // APB slave with random wait states, at most MAX_WAIT in a row
  always @(negedge clock) begin
    logic [31:0] r;
    r = draw_random();
    if (!penable) begin
      wait_count = 0;
      pready = r[0];
    end else if (wait_count >= MAX_WAIT) begin
      pready = 1'b1;
    end else begin
      pready = r[0];
      if (!pready) wait_count++;
    end
  end

  a_reset_pc: assert property (@(posedge clock) $fell(reset) |-> inst_addr == 32'h0)
    else begin
      fetch_errors++;
      $display("mismatch reset_pc: expected %h actual %h", 32'h0, $sampled(inst_addr));
    end

  a_reset_psel: assert property (@(posedge clock) $fell(reset) |-> !psel)
    else begin
      apb_errors++;
      $display("psel is high right after reset");
    end

  a_pc_step: assert property (@(posedge clock) disable iff (reset)
    !prev_reset && !psel |-> inst_addr == prev_inst_addr + 32'd4)
    else begin
      fetch_errors++;
      $display("mismatch pc_step: expected %h actual %h",
               $sampled(prev_inst_addr) + 32'd4, $sampled(inst_addr));
    end

  a_pc_hold: assert property (@(posedge clock) disable iff (reset)
    psel |-> inst_addr == prev_inst_addr)
    else begin
      fetch_errors++;
      $display("mismatch pc_hold: expected %h actual %h",
               $sampled(prev_inst_addr), $sampled(inst_addr));
    end

  a_apb_setup: assert property (@(posedge clock) disable iff (reset) $rose(psel) |-> !penable)
    else begin
      apb_errors++;
      $display("penable was already high in the first psel cycle");
    end

  a_apb_access: assert property (@(posedge clock) disable iff (reset) $rose(psel) |=> penable)
    else begin
      apb_errors++;
      $display("penable did not follow the setup cycle");
    end

  a_apb_enable: assert property (@(posedge clock) disable iff (reset) penable |-> psel)
    else begin
      apb_errors++;
      $display("penable is high without psel");
    end

  a_apb_hold: assert property (@(posedge clock) disable iff (reset)
    psel && !(penable && pready) |=> psel && pwrite && $stable(paddr) && $stable(pwdata))
    else begin
      apb_errors++;
      $display("transfer changed before pready at address %h", $sampled(paddr));
    end

  a_store_expected: assert property (@(posedge clock) disable iff (reset) xfer |-> exp_valid)
    else begin
      store_errors++;
      $display("APB write to %h with no store left in the reference model", $sampled(paddr));
    end

  a_store_addr: assert property (@(posedge clock) disable iff (reset)
    xfer && exp_valid |-> paddr == exp_paddr)
    else begin
      store_errors++;
      $display("mismatch store_addr[%0d]: expected %h actual %h",
               store_idx, exp_paddr, $sampled(paddr));
    end

  a_store_data: assert property (@(posedge clock) disable iff (reset)
    xfer && exp_valid |-> pwdata == exp_pwdata)
    else begin
      store_errors++;
      $display("mismatch store_data[%0d]: expected %h actual %h",
               store_idx, exp_pwdata, $sampled(pwdata));
    end

  a_store_x0: assert property (@(posedge clock) disable iff (reset)
    xfer && exp_valid && exp_zero_now |-> pwdata == 32'h0)
    else begin
      store_errors++;
      $display("mismatch store_x0[%0d]: expected %h actual %h",
               store_idx, 32'h0, $sampled(pwdata));
    end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: pipeline did not drain within %0d ns", WATCHDOG_NS);
    $display("Verification failed");
    $finish;
  end

  initial begin
    int missing;
    build_program();
    repeat (4) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    // Program plus NOP padding fetched means every store has left the pipeline
    wait (inst_addr >= DONE_ADDR);
    repeat (2) @(negedge clock);
    missing = exp_count - store_idx;
    if (missing != 0) begin
      $display("%0d of %0d predicted stores never reached the APB bus", missing, exp_count);
    end
    $display("errors: fetch %0d, apb %0d, store %0d, missing stores %0d",
             fetch_errors, apb_errors, store_errors, missing);
    if (fetch_errors + apb_errors + store_errors + missing == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* core_top.sv */
`timescale 1ns/100ps
`default_nettype none

module core_top (
  input  logic              clock,
  input  logic              reset,
  output rv_isa_pkg::word_t inst_addr,
  input  rv_isa_pkg::inst_t inst,
  output rv_isa_pkg::word_t paddr,
  output logic              psel,
  output logic              penable,
  output logic              pwrite,
  output rv_isa_pkg::word_t pwdata,
  input  logic              pready
);

  logic stall;
  rv_isa_pkg::inst_t if_inst;
  logic wb_we;
  rv_isa_pkg::reg_addr_t wb_rd;
  rv_isa_pkg::word_t wb_data;

  id_ex_if id_ex ();
  ex_mem_if ex_mem ();

  fetch_stage u_fetch_stage (
    .clock     (clock),
    .reset     (reset),
    .stall     (stall),
    .inst      (inst),
    .inst_addr (inst_addr),
    .if_inst   (if_inst)
  );

  decode_stage u_decode_stage (
    .clock   (clock),
    .reset   (reset),
    .stall   (stall),
    .if_inst (if_inst),
    .wb_we   (wb_we),
    .wb_rd   (wb_rd),
    .wb_data (wb_data),
    .id_ex   (id_ex.decode)
  );

  execute_stage u_execute_stage (
    .clock   (clock),
    .reset   (reset),
    .stall   (stall),
    .id_ex   (id_ex.execute),
    .wb_we   (wb_we),
    .wb_rd   (wb_rd),
    .wb_data (wb_data),
    .ex_mem  (ex_mem.execute)
  );

  memory_stage u_memory_stage (
    .clock   (clock),
    .reset   (reset),
    .ex_mem  (ex_mem.memory),
    .stall   (stall),
    .wb_we   (wb_we),
    .wb_rd   (wb_rd),
    .wb_data (wb_data),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .pready  (pready)
  );

endmodule

`default_nettype wire

/* memory_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module memory_stage (
  input  logic                  clock,
  input  logic                  reset,
  ex_mem_if.memory              ex_mem,
  output logic                  stall,
  output logic                  wb_we,
  output rv_isa_pkg::reg_addr_t wb_rd,
  output rv_isa_pkg::word_t     wb_data,
  output rv_isa_pkg::word_t     paddr,
  output logic                  psel,
  output logic                  penable,
  output logic                  pwrite,
  output rv_isa_pkg::word_t     pwdata,
  input  logic                  pready
);

  rv_pipe_pkg::apb_state_t state;
  rv_pipe_pkg::apb_state_t state_next;

  always_comb begin
    state_next = state;
    case (state)
      rv_pipe_pkg::ApbIdle: begin
        if (ex_mem.store) begin
          state_next = rv_pipe_pkg::ApbSetup;
        end
      end
      rv_pipe_pkg::ApbSetup: state_next = rv_pipe_pkg::ApbAccess;
      rv_pipe_pkg::ApbAccess: begin
        if (pready) begin
          state_next = rv_pipe_pkg::ApbIdle;
        end
      end
      default: state_next = rv_pipe_pkg::ApbIdle;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= rv_pipe_pkg::ApbIdle;
    end else begin
      state <= state_next;
    end
  end

  // Only writes go out, so pwrite follows psel
  assign psel = (state != rv_pipe_pkg::ApbIdle);
  assign penable = (state == rv_pipe_pkg::ApbAccess);
  assign pwrite = psel;
  // EX/MEM is frozen while the store is pending
  assign paddr = ex_mem.alu_y;
  assign pwdata = ex_mem.store_data;

  // Released on the completion edge so the store leaves EX/MEM once
  assign stall = ex_mem.store && !(penable && pready);

  always_ff @(posedge clock) begin
    if (reset) begin
      wb_we <= 1'b0;
      wb_rd <= '0;
      wb_data <= '0;
    end else if (!stall) begin
      wb_we <= ex_mem.reg_we;
      wb_rd <= ex_mem.rd;
      wb_data <= ex_mem.alu_y;
    end
  end

  // Setup phase always comes first
  a_penable_after_psel: assert property (@(posedge clock) disable iff (reset)
    penable |-> $past(psel))
    else $error("memory_stage: penable without a setup cycle");

  a_apb_stable: assert property (@(posedge clock) disable iff (reset)
    (psel && !(penable && pready)) |=> $stable(paddr) && $stable(pwdata) && pwrite)
    else $error("memory_stage: address or data changed mid-transfer");

endmodule

`default_nettype wire

/* execute_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module execute_stage (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  stall,
  id_ex_if.execute              id_ex,
  input  logic                  wb_we,
  input  rv_isa_pkg::reg_addr_t wb_rd,
  input  rv_isa_pkg::word_t     wb_data,
  ex_mem_if.execute             ex_mem
);

  rv_pipe_pkg::fwd_sel_t rs1_sel;
  rv_pipe_pkg::fwd_sel_t rs2_sel;
  rv_isa_pkg::word_t rs1_fwd;
  rv_isa_pkg::word_t rs2_fwd;
  rv_isa_pkg::word_t alu_b;
  rv_isa_pkg::word_t alu_y;

  // MEM has the younger result, so it wins over WB
  function automatic rv_pipe_pkg::fwd_sel_t pick_source(
    input rv_isa_pkg::reg_addr_t addr,
    input logic                  mem_we,
    input rv_isa_pkg::reg_addr_t mem_rd,
    input logic                  last_we,
    input rv_isa_pkg::reg_addr_t last_rd
  );
    if (mem_we && mem_rd == addr) begin
      return rv_pipe_pkg::FwdMem;
    end else if (last_we && last_rd == addr) begin
      return rv_pipe_pkg::FwdWb;
    end
    return rv_pipe_pkg::FwdNone;
  endfunction

  function automatic rv_isa_pkg::word_t pick_value(
    input rv_pipe_pkg::fwd_sel_t sel,
    input rv_isa_pkg::word_t     reg_value,
    input rv_isa_pkg::word_t     mem_value,
    input rv_isa_pkg::word_t     last_value
  );
    case (sel)
      rv_pipe_pkg::FwdMem: return mem_value;
      rv_pipe_pkg::FwdWb: return last_value;
      default: return reg_value;
    endcase
  endfunction

  assign rs1_sel = pick_source(id_ex.rs1_addr, ex_mem.reg_we, ex_mem.rd, wb_we, wb_rd);
  assign rs2_sel = pick_source(id_ex.rs2_addr, ex_mem.reg_we, ex_mem.rd, wb_we, wb_rd);
  assign rs1_fwd = pick_value(rs1_sel, id_ex.rs1_data, ex_mem.alu_y, wb_data);
  assign rs2_fwd = pick_value(rs2_sel, id_ex.rs2_data, ex_mem.alu_y, wb_data);

  assign alu_b = id_ex.use_imm ? id_ex.imm : rs2_fwd;

  always_comb begin
    case (id_ex.alu_op)
      rv_isa_pkg::AluAdd: alu_y = rs1_fwd + alu_b;
      rv_isa_pkg::AluSub: alu_y = rs1_fwd - alu_b;
      rv_isa_pkg::AluAnd: alu_y = rs1_fwd & alu_b;
      rv_isa_pkg::AluOr: alu_y = rs1_fwd | alu_b;
      rv_isa_pkg::AluXor: alu_y = rs1_fwd ^ alu_b;
      rv_isa_pkg::AluSlt: alu_y = {31'b0, $signed(rs1_fwd) < $signed(alu_b)};
      rv_isa_pkg::AluSll: alu_y = rs1_fwd << alu_b[4:0];
      rv_isa_pkg::AluSrl: alu_y = rs1_fwd >> alu_b[4:0];
      rv_isa_pkg::AluPassB: alu_y = alu_b;
      default: alu_y = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      ex_mem.alu_y <= '0;
      ex_mem.store_data <= '0;
      ex_mem.rd <= '0;
      ex_mem.reg_we <= 1'b0;
      ex_mem.store <= 1'b0;
    end else if (!stall) begin
      ex_mem.alu_y <= alu_y;
      // Store data is the forwarded rs2, never the immediate
      ex_mem.store_data <= rs2_fwd;
      ex_mem.rd <= id_ex.rd;
      ex_mem.reg_we <= id_ex.reg_we;
      ex_mem.store <= id_ex.store;
    end
  end

  // Register file, EX/MEM and MEM/WB all feed these
  a_fwd_known: assert property (@(posedge clock) disable iff (reset)
    !$isunknown({rs1_fwd, rs2_fwd}))
    else $error("execute_stage: forwarded operand is unknown");

endmodule

`default_nettype wire

/* decode_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module decode_stage (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  stall,
  input  rv_isa_pkg::inst_t     if_inst,
  input  logic                  wb_we,
  input  rv_isa_pkg::reg_addr_t wb_rd,
  input  rv_isa_pkg::word_t     wb_data,
  id_ex_if.decode               id_ex
);

  rv_isa_pkg::opcode_t opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  rv_isa_pkg::reg_addr_t rs1_addr;
  rv_isa_pkg::reg_addr_t rs2_addr;
  rv_isa_pkg::reg_addr_t rd;
  rv_isa_pkg::word_t rs1_data;
  rv_isa_pkg::word_t rs2_data;
  rv_isa_pkg::word_t dec_imm;
  rv_isa_pkg::alu_op_t dec_alu_op;
  logic dec_use_imm;
  logic dec_writes;
  logic dec_store;

  assign opcode = rv_isa_pkg::opcode_t'(if_inst[6:0]);
  assign rd = if_inst[11:7];
  assign funct3 = if_inst[14:12];
  assign rs1_addr = if_inst[19:15];
  assign rs2_addr = if_inst[24:20];
  assign funct7 = if_inst[31:25];

  register_file u_register_file (
    .clock    (clock),
    .reset    (reset),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wb_we    (wb_we),
    .wb_rd    (wb_rd),
    .wb_data  (wb_data)
  );

  // Anything not listed falls back to a NOP
  always_comb begin
    dec_alu_op = rv_isa_pkg::AluAdd;
    dec_use_imm = 1'b0;
    dec_imm = '0;
    dec_writes = 1'b0;
    dec_store = 1'b0;
    case (opcode)
      rv_isa_pkg::OpReg: begin
        // SUB is the only R-type with funct7[5] set
        dec_writes = (funct7 == 7'b0) || (funct7 == 7'b0100000 && funct3 == 3'b000);
        case (funct3)
          3'b000: dec_alu_op = funct7[5] ? rv_isa_pkg::AluSub : rv_isa_pkg::AluAdd;
          3'b001: dec_alu_op = rv_isa_pkg::AluSll;
          3'b010: dec_alu_op = rv_isa_pkg::AluSlt;
          3'b100: dec_alu_op = rv_isa_pkg::AluXor;
          3'b101: dec_alu_op = rv_isa_pkg::AluSrl;
          3'b110: dec_alu_op = rv_isa_pkg::AluOr;
          3'b111: dec_alu_op = rv_isa_pkg::AluAnd;
          default: dec_writes = 1'b0;
        endcase
      end
      rv_isa_pkg::OpImm: begin
        dec_use_imm = 1'b1;
        dec_imm = {{20{if_inst[31]}}, if_inst[31:20]};
        dec_writes = 1'b1;
        case (funct3)
          3'b000: dec_alu_op = rv_isa_pkg::AluAdd;
          3'b010: dec_alu_op = rv_isa_pkg::AluSlt;
          3'b100: dec_alu_op = rv_isa_pkg::AluXor;
          3'b110: dec_alu_op = rv_isa_pkg::AluOr;
          3'b111: dec_alu_op = rv_isa_pkg::AluAnd;
          default: dec_writes = 1'b0;
        endcase
      end
      rv_isa_pkg::OpLui: begin
        dec_use_imm = 1'b1;
        dec_imm = {if_inst[31:12], 12'b0};
        dec_alu_op = rv_isa_pkg::AluPassB;
        dec_writes = 1'b1;
      end
      rv_isa_pkg::OpStore: begin
        // Word stores only
        dec_use_imm = 1'b1;
        dec_imm = {{20{if_inst[31]}}, if_inst[31:25], if_inst[11:7]};
        dec_store = (funct3 == 3'b010);
      end
      default: begin
        dec_writes = 1'b0;
      end
    endcase
  end

  // ID/EX register, reset to addi x0, x0, 0 with no side effects
  always_ff @(posedge clock) begin
    if (reset) begin
      id_ex.rs1_addr <= '0;
      id_ex.rs2_addr <= '0;
      id_ex.rs1_data <= '0;
      id_ex.rs2_data <= '0;
      id_ex.imm <= '0;
      id_ex.use_imm <= 1'b1;
      id_ex.alu_op <= rv_isa_pkg::AluAdd;
      id_ex.rd <= '0;
      id_ex.reg_we <= 1'b0;
      id_ex.store <= 1'b0;
    end else if (!stall) begin
      id_ex.rs1_addr <= rs1_addr;
      id_ex.rs2_addr <= rs2_addr;
      id_ex.rs1_data <= rs1_data;
      id_ex.rs2_data <= rs2_data;
      id_ex.imm <= dec_imm;
      id_ex.use_imm <= dec_use_imm;
      id_ex.alu_op <= dec_alu_op;
      id_ex.rd <= rd;
      id_ex.reg_we <= dec_writes && (rd != '0);
      id_ex.store <= dec_store;
    end
  end

  // The register file has no storage for x0
  a_no_x0_write: assert property (@(posedge clock) disable iff (reset)
    wb_we |-> wb_rd != '0)
    else $error("decode_stage: write-back targets x0");

endmodule

`default_nettype wire

/* register_file.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rv_macros.svh"

module register_file (
  input  logic                  clock,
  input  logic                  reset,
  input  rv_isa_pkg::reg_addr_t rs1_addr,
  input  rv_isa_pkg::reg_addr_t rs2_addr,
  output rv_isa_pkg::word_t     rs1_data,
  output rv_isa_pkg::word_t     rs2_data,
  input  logic                  wb_we,
  input  rv_isa_pkg::reg_addr_t wb_rd,
  input  rv_isa_pkg::word_t     wb_data
);

  // x0 has no storage
  rv_isa_pkg::word_t regs [1:`RV_REG_COUNT-1];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 1; i < `RV_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_we) begin
      regs[wb_rd] <= wb_data;
    end
  end

  // Same-cycle WB write is seen by the ID read
  function automatic rv_isa_pkg::word_t read_port(input rv_isa_pkg::reg_addr_t addr);
    if (addr == '0) begin
      return '0;
    end else if (wb_we && wb_rd == addr) begin
      return wb_data;
    end
    return regs[addr];
  endfunction

  always_comb begin
    rs1_data = read_port(rs1_addr);
  end

  always_comb begin
    rs2_data = read_port(rs2_addr);
  end

endmodule

`default_nettype wire

/* fetch_stage.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rv_macros.svh"

module fetch_stage (
  input  logic                clock,
  input  logic                reset,
  input  logic                stall,
  input  rv_isa_pkg::inst_t   inst,
  output rv_isa_pkg::word_t   inst_addr,
  output rv_isa_pkg::inst_t   if_inst
);

  rv_isa_pkg::word_t pc;

  // PC and IF/ID move together, both frozen on a stall
  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= `RV_RESET_PC;
      if_inst <= `RV_NOP;
    end else if (!stall) begin
      pc <= pc + `RV_PC_STEP;
      if_inst <= inst;
    end
  end

  // Instruction memory is read combinationally
  assign inst_addr = pc;

endmodule

`default_nettype wire

/* pipe_if.sv */
`timescale 1ns/100ps
`default_nettype none

// ID/EX register contents
interface id_ex_if;
  rv_isa_pkg::reg_addr_t rs1_addr;
  rv_isa_pkg::reg_addr_t rs2_addr;
  rv_isa_pkg::word_t rs1_data;
  rv_isa_pkg::word_t rs2_data;
  rv_isa_pkg::word_t imm;
  logic use_imm;
  rv_isa_pkg::alu_op_t alu_op;
  rv_isa_pkg::reg_addr_t rd;
  logic reg_we;
  logic store;

  modport decode (
    output rs1_addr, rs2_addr, rs1_data, rs2_data, imm, use_imm, alu_op, rd, reg_we, store
  );

  modport execute (
    input rs1_addr, rs2_addr, rs1_data, rs2_data, imm, use_imm, alu_op, rd, reg_we, store
  );
endinterface

// EX/MEM register contents
interface ex_mem_if;
  // Also the store address
  rv_isa_pkg::word_t alu_y;
  rv_isa_pkg::word_t store_data;
  rv_isa_pkg::reg_addr_t rd;
  logic reg_we;
  logic store;

  modport execute (
    output alu_y, store_data, rd, reg_we, store
  );

  modport memory (
    input alu_y, store_data, rd, reg_we, store
  );
endinterface

`default_nettype wire

/* rv_pipe_pkg.sv */
`default_nettype none

package rv_pipe_pkg;

  // Operand source for the EX stage
  typedef enum logic [1:0] {
    FwdNone,
    FwdMem,
    FwdWb
  } fwd_sel_t;

  // APB master states
  typedef enum logic [1:0] {
    ApbIdle,
    ApbSetup,
    ApbAccess
  } apb_state_t;

endpackage

`default_nettype wire

/* rv_isa_pkg.sv */
`default_nettype none

`include "rv_macros.svh"

package rv_isa_pkg;

  typedef logic [`RV_XLEN-1:0] word_t;
  typedef logic [`RV_REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [31:0] inst_t;

  // Major opcodes handled by the core
  typedef enum logic [6:0] {
    OpReg   = 7'b0110011,
    OpImm   = 7'b0010011,
    OpLui   = 7'b0110111,
    OpStore = 7'b0100011
  } opcode_t;

  typedef enum logic [3:0] {
    AluAdd,
    AluSub,
    AluAnd,
    AluOr,
    AluXor,
    AluSlt,
    AluSll,
    AluSrl,
    // LUI passes the U immediate through
    AluPassB
  } alu_op_t;

endpackage

`default_nettype wire

/* rv_macros.svh */
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// Data path width for RV32
`define RV_XLEN 32

// Register file geometry
`define RV_REG_ADDR_W 5
`define RV_REG_COUNT 32

// Program counter
`define RV_RESET_PC 32'h0000_0000
`define RV_PC_STEP 32'd4

// addi x0, x0, 0
`define RV_NOP 32'h0000_0013

`endif
